/* source/isa_pkg.sv */
package isa_pkg;

    localparam int WORD_BITS    = 32;  // Data path and address width
    localparam int REG_NUM_BITS = 5;   // 32 architectural registers
    localparam int ALU_OP_BITS  = 3;   // Room for eight ALU codes

    typedef logic [WORD_BITS-1:0]    word_t;     // Data word or byte address
    typedef logic [REG_NUM_BITS-1:0] reg_num_t;  // Destination register number

    // ALU function select, driven with every operation
    typedef enum logic [ALU_OP_BITS-1:0] {
        alu_add = 3'd0,  // a + b
        alu_sub = 3'd1,  // a - b
        alu_and = 3'd2,  // Bitwise and
        alu_or  = 3'd3,  // Bitwise or
        alu_xor = 3'd4,  // Bitwise xor
        alu_slt = 3'd5   // Signed a < b gives 1
    } alu_op_e;

    localparam reg_num_t REG_ZERO = '0;  // Hard zero register

endpackage

/* source/mem_map_pkg.sv */
package mem_map_pkg;

    localparam int WORD_INDEX_BITS  = 8;                     // Word select field width
    localparam int BYTE_OFFSET_BITS = 2;                     // Byte lanes in a word
    localparam int MEM_WORDS        = 1 << WORD_INDEX_BITS;  // 256 words of data RAM

    // Address bits 9:2 pick the word and bits 1:0 must stay zero
    typedef logic [WORD_INDEX_BITS-1:0]  word_index_t;   // RAM word index
    typedef logic [BYTE_OFFSET_BITS-1:0] byte_offset_t;  // Offset inside a word

endpackage

/* source/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,       // One cycle per operation
    input  isa_pkg::alu_op_e  alu_op,
    input  isa_pkg::word_t    operand_a,
    input  isa_pkg::word_t    operand_b,
    input  isa_pkg::word_t    imm,            // Offset for loads and stores
    input  isa_pkg::reg_num_t rd,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic              reg_write,
    input  logic              mem_to_reg,
    output logic              ex_valid,
    output logic              ex_mem_read,
    output logic              ex_mem_write,
    output logic              ex_reg_write,
    output logic              ex_mem_to_reg,
    output isa_pkg::word_t    ex_result,      // ALU value or effective address
    output isa_pkg::word_t    ex_store_data,
    output isa_pkg::reg_num_t ex_rd
);
    import isa_pkg::*;

    word_t alu_result;   // Output of the ALU proper
    word_t next_result;  // Value captured into ex_result
    logic  is_mem_op;    // Load or store in this cycle

    assign is_mem_op = mem_read | mem_write;

    always_comb
    begin
        case (alu_op)
            alu_add: alu_result = operand_a + operand_b;
            alu_sub: alu_result = operand_a - operand_b;
            alu_and: alu_result = operand_a & operand_b;
            alu_or:  alu_result = operand_a | operand_b;
            alu_xor: alu_result = operand_a ^ operand_b;
            alu_slt: alu_result = word_t'($signed(operand_a) < $signed(operand_b));
            default: alu_result = '0;  // Unused codes give zero
        endcase
    end

    // Memory ops bypass the ALU and use base plus offset
    assign next_result = is_mem_op ? (operand_a + imm) : alu_result;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ex_valid      <= 1'b0;
            ex_mem_read   <= 1'b0;
            ex_mem_write  <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_result     <= '0;
            ex_store_data <= '0;
            ex_rd         <= '0;
        end
        else begin
            ex_valid      <= in_valid;
            ex_mem_read   <= in_valid & mem_read;    // Bubble never loads
            ex_mem_write  <= in_valid & mem_write;   // Bubble never stores
            ex_reg_write  <= in_valid & reg_write;   // Bubble never writes
            ex_mem_to_reg <= in_valid & mem_to_reg;
            if (in_valid)
            begin
                ex_result     <= next_result;
                ex_store_data <= operand_b;          // Store value rides along
                ex_rd         <= rd;
            end
        end
    end

    // An operation is either a load or a store, not both
    assert property (@(posedge clk) disable iff (rst) in_valid |-> !(mem_read && mem_write))
        else $error("execute_stage: load and store requested together");

endmodule

/* source/memory_stage.sv */
`timescale 1ns/1ps

module memory_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ex_valid,
    input  logic                     ex_mem_read,
    input  logic                     ex_mem_write,
    input  logic                     ex_reg_write,
    input  logic                     ex_mem_to_reg,
    input  isa_pkg::word_t           ex_result,         // Byte address for memory ops
    input  isa_pkg::word_t           ex_store_data,
    input  isa_pkg::reg_num_t        ex_rd,
    input  isa_pkg::word_t           ram_read_data,     // Combinational RAM answer
    output mem_map_pkg::word_index_t ram_index,
    output isa_pkg::word_t           ram_write_data,
    output logic                     ram_write_enable,
    output logic                     mem_valid,
    output logic                     mem_reg_write,
    output logic                     mem_mem_to_reg,
    output isa_pkg::word_t           mem_load_data,
    output isa_pkg::word_t           mem_alu_result,
    output isa_pkg::reg_num_t        mem_rd
);
    import isa_pkg::*;
    import mem_map_pkg::*;

    word_t        held_store_data;  // Store value for the RAM
    logic         held_load;        // Valid load held this cycle
    logic         held_store;       // Valid store held this cycle
    byte_offset_t held_offset;      // Low address bits

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            held_store_data <= '0;
            held_load       <= 1'b0;
            held_store      <= 1'b0;
            mem_valid       <= 1'b0;
            mem_reg_write   <= 1'b0;
            mem_mem_to_reg  <= 1'b0;
            mem_alu_result  <= '0;
            mem_rd          <= '0;
        end
        else begin
            held_load      <= ex_valid & ex_mem_read;
            held_store     <= ex_valid & ex_mem_write;
            mem_valid      <= ex_valid;
            mem_reg_write  <= ex_reg_write;     // Already cleared on bubbles
            mem_mem_to_reg <= ex_mem_to_reg;
            if (ex_valid)
            begin
                held_store_data <= ex_store_data;
                mem_alu_result  <= ex_result;   // Doubles as the held address
                mem_rd          <= ex_rd;
            end
        end
    end

    // RAM is driven from the held values during the whole stage cycle
    assign ram_index        = mem_alu_result[BYTE_OFFSET_BITS +: WORD_INDEX_BITS];
    assign ram_write_data   = held_store_data;
    assign ram_write_enable = held_store;   // Write lands on the closing edge
    assign held_offset      = mem_alu_result[BYTE_OFFSET_BITS-1:0];

    // Read data goes straight on and writeback captures it on the next edge
    assign mem_load_data = held_load ? ram_read_data : '0;

    // Execute must hand over word aligned addresses for loads and stores
    assert property (@(posedge clk) disable iff (rst)
        (held_load || held_store) |-> (held_offset == '0))
        else $error("memory_stage: misaligned address %h", mem_alu_result);

endmodule

/* source/data_ram.sv */
`timescale 1ns/1ps

module data_ram (
    input  logic                     clk,
    input  mem_map_pkg::word_index_t ram_index,         // Shared read and write index
    input  isa_pkg::word_t           ram_write_data,
    input  logic                     ram_write_enable,
    output isa_pkg::word_t           ram_read_data      // Valid in the same cycle
);
    import isa_pkg::*;
    import mem_map_pkg::*;

    word_t mem_array [MEM_WORDS];  // Contents undefined until stored

    // Asynchronous read port
    assign ram_read_data = mem_array[ram_index];

    // Single write port on the rising edge
    always_ff @(posedge clk)
    begin
        if (ram_write_enable)
        begin
            mem_array[ram_index] <= ram_write_data;
        end
    end

endmodule

/* source/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              mem_valid,
    input  logic              mem_reg_write,
    input  logic              mem_mem_to_reg,   // Pick load data over ALU value
    input  isa_pkg::word_t    mem_load_data,
    input  isa_pkg::word_t    mem_alu_result,
    input  isa_pkg::reg_num_t mem_rd,
    output logic              wb_valid,
    output logic              wb_reg_write,
    output isa_pkg::reg_num_t wb_rd,
    output isa_pkg::word_t    wb_data
);
    import isa_pkg::*;

    word_t select_data;  // Value headed for the register file

    assign select_data = mem_mem_to_reg ? mem_load_data : mem_alu_result;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
            wb_rd        <= '0;
            wb_data      <= '0;
        end
        else begin
            wb_valid     <= mem_valid;
            wb_reg_write <= mem_valid & mem_reg_write;
            if (mem_valid)
            begin
                wb_rd   <= mem_rd;
                wb_data <= select_data;
            end
        end
    end

    // r0 is the hard zero so no request may target it
    assert property (@(posedge clk) disable iff (rst)
        (mem_valid && mem_reg_write) |=> (wb_rd != REG_ZERO))
        else $error("writeback_stage: register write to r0");

endmodule

/* source/pipe_backend_top.sv */
`timescale 1ns/1ps

module pipe_backend_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  isa_pkg::alu_op_e  alu_op,
    input  isa_pkg::word_t    operand_a,
    input  isa_pkg::word_t    operand_b,
    input  isa_pkg::word_t    imm,
    input  isa_pkg::reg_num_t rd,
    input  logic              mem_read,
    input  logic              mem_write,
    input  logic              reg_write,
    input  logic              mem_to_reg,
    output logic              wb_valid,        // Three cycles after in_valid
    output logic              wb_reg_write,
    output isa_pkg::reg_num_t wb_rd,
    output isa_pkg::word_t    wb_data
);
    import isa_pkg::*;
    import mem_map_pkg::*;

    // Execute to memory
    logic     ex_valid;
    logic     ex_mem_read;
    logic     ex_mem_write;
    logic     ex_reg_write;
    logic     ex_mem_to_reg;
    word_t    ex_result;
    word_t    ex_store_data;
    reg_num_t ex_rd;

    // Memory stage and RAM
    word_index_t ram_index;
    word_t       ram_write_data;
    logic        ram_write_enable;
    word_t       ram_read_data;

    // Memory to writeback
    logic     mem_valid;
    logic     mem_reg_write;
    logic     mem_mem_to_reg;
    word_t    mem_load_data;
    word_t    mem_alu_result;
    reg_num_t mem_rd;

    execute_stage execute_stage_inst (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .alu_op        (alu_op),
        .operand_a     (operand_a),
        .operand_b     (operand_b),
        .imm           (imm),
        .rd            (rd),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .reg_write     (reg_write),
        .mem_to_reg    (mem_to_reg),
        .ex_valid      (ex_valid),
        .ex_mem_read   (ex_mem_read),
        .ex_mem_write  (ex_mem_write),
        .ex_reg_write  (ex_reg_write),
        .ex_mem_to_reg (ex_mem_to_reg),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd)
    );

    memory_stage memory_stage_inst (
        .clk              (clk),
        .rst              (rst),
        .ex_valid         (ex_valid),
        .ex_mem_read      (ex_mem_read),
        .ex_mem_write     (ex_mem_write),
        .ex_reg_write     (ex_reg_write),
        .ex_mem_to_reg    (ex_mem_to_reg),
        .ex_result        (ex_result),
        .ex_store_data    (ex_store_data),
        .ex_rd            (ex_rd),
        .ram_read_data    (ram_read_data),
        .ram_index        (ram_index),
        .ram_write_data   (ram_write_data),
        .ram_write_enable (ram_write_enable),
        .mem_valid        (mem_valid),
        .mem_reg_write    (mem_reg_write),
        .mem_mem_to_reg   (mem_mem_to_reg),
        .mem_load_data    (mem_load_data),
        .mem_alu_result   (mem_alu_result),
        .mem_rd           (mem_rd)
    );

    data_ram data_ram_inst (
        .clk              (clk),
        .ram_index        (ram_index),
        .ram_write_data   (ram_write_data),
        .ram_write_enable (ram_write_enable),
        .ram_read_data    (ram_read_data)
    );

    writeback_stage writeback_stage_inst (
        .clk            (clk),
        .rst            (rst),
        .mem_valid      (mem_valid),
        .mem_reg_write  (mem_reg_write),
        .mem_mem_to_reg (mem_mem_to_reg),
        .mem_load_data  (mem_load_data),
        .mem_alu_result (mem_alu_result),
        .mem_rd         (mem_rd),
        .wb_valid       (wb_valid),
        .wb_reg_write   (wb_reg_write),
        .wb_rd          (wb_rd),
        .wb_data        (wb_data)
    );

endmodule

/* dv/backend_model.svh */
`ifndef BACKEND_MODEL_SVH
`define BACKEND_MODEL_SVH

// One expected writeback per issued operation
typedef struct packed {
    logic     reg_write;
    reg_num_t rd;
    word_t    data;
} wb_rec_t;

wb_rec_t     expect_q [$];           // Oldest first as results retire in order
word_t       model_mem [MEM_WORDS];  // Mirror of the data RAM
word_index_t stored_q [$];           // Words known to hold a value

function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
    case (op)
        alu_add: return a + b;
        alu_sub: return a - b;
        alu_and: return a & b;
        alu_or:  return a | b;
        alu_xor: return a ^ b;
        alu_slt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;  // Signed compare
        default: return '0;
    endcase
endfunction

// Expected writeback of one operation with the memory mirror updated at issue
function automatic wb_rec_t model_step(input alu_op_e op, input word_t a, input word_t b,
                                       input word_t offset, input reg_num_t dest,
                                       input logic ld, input logic st);
    wb_rec_t     rec;
    word_t       addr;
    word_index_t idx;
    addr          = a + offset;
    idx           = addr[9:2];   // Word select with bits 1:0 zero
    rec.reg_write = ~st;         // Stores leave the registers alone
    rec.rd        = dest;
    rec.data      = (ld || st) ? addr : alu_model(op, a, b);  // Address rides the ALU path
    if (st)
    begin
        model_mem[idx] = b;
        stored_q.push_back(idx);
    end
    if (ld)
    begin
        rec.data = model_mem[idx];
    end
    return rec;
endfunction

`endif

/* dv/pipe_backend_tb.sv */
`timescale 1ns/1ps

module pipe_backend_tb;
    import isa_pkg::*;
    import mem_map_pkg::*;

    localparam int ALU_ROUNDS  = 4;    // Back-to-back passes over all ALU ops
    localparam int MEM_PAIRS   = 8;    // Store, load right after, load later
    localparam int RANDOM_OPS  = 300;
    localparam int MAX_GAP     = 3;    // Longest idle run in the random stream
    localparam int OP_COUNT    = ALU_ROUNDS * 6 + 2 + MEM_PAIRS * 3 + RANDOM_OPS;
    localparam int IDLE_CYCLES = 16 + 8 + 20 + RANDOM_OPS * MAX_GAP;
    localparam int CYCLE_LIMIT = OP_COUNT + IDLE_CYCLES + 20;

    logic     clk;
    logic     rst;
    logic     in_valid;
    alu_op_e  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    word_t    imm;
    reg_num_t rd;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     mem_to_reg;
    logic     wb_valid;
    logic     wb_reg_write;
    reg_num_t wb_rd;
    word_t    wb_data;

    integer  seed        = 71582;
    int      cycle_count = 0;
    alu_op_e all_ops [6] = '{alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt};

    `include "backend_model.svh"

    pipe_backend_top pipe_backend_top_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .alu_op       (alu_op),
        .operand_a    (operand_a),
        .operand_b    (operand_b),
        .imm          (imm),
        .rd           (rd),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .reg_write    (reg_write),
        .mem_to_reg   (mem_to_reg),
        .wb_valid     (wb_valid),
        .wb_reg_write (wb_reg_write),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected)
        begin
            report_failure($sformatf("ERROR %s got 0x%h expected 0x%h", name, got, expected));
        end
    endtask

    function automatic reg_num_t random_rd();
        word_t pick;
        pick = {$random(seed)} % 31 + 1;  // r1 to r31 since r0 is the hard zero
        return pick[4:0];
    endfunction

    // Random upper bits, chosen word, aligned
    function automatic word_t make_addr(input word_index_t idx);
        word_t upper;
        upper = $random(seed);
        return {upper[31:10], idx, 2'b00};
    endfunction

    task automatic issue_op(input alu_op_e op, input word_t a, input word_t b,
                            input word_t offset, input reg_num_t dest,
                            input logic ld, input logic st);
        wb_rec_t rec;
        @(posedge clk);
        in_valid   <= 1'b1;
        alu_op     <= op;
        operand_a  <= a;
        operand_b  <= b;
        imm        <= offset;
        rd         <= dest;
        mem_read   <= ld;
        mem_write  <= st;
        reg_write  <= ~st;
        mem_to_reg <= ld;
        rec = model_step(op, a, b, offset, dest, ld, st);
        expect_q.push_back(rec);
    endtask

    task automatic idle_cycles(input int count);
        repeat (count)
        begin
            @(posedge clk);
            in_valid   <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            reg_write  <= 1'b0;
            mem_to_reg <= 1'b0;
        end
    endtask

    task automatic store_word(input word_index_t idx, input word_t value);
        word_t addr;
        word_t offset;
        addr   = make_addr(idx);
        offset = $random(seed);  // Base is whatever reaches addr
        issue_op(alu_add, addr - offset, value, offset, random_rd(), 1'b0, 1'b1);
    endtask

    task automatic load_word(input word_index_t idx);
        word_t addr;
        word_t offset;
        word_t junk;
        addr   = make_addr(idx);
        offset = $random(seed);
        junk   = $random(seed);  // operand_b unused by a load
        issue_op(alu_add, addr - offset, junk, offset, random_rd(), 1'b1, 1'b0);
    endtask

    task automatic random_alu();
        int    sel;
        word_t a;
        word_t b;
        word_t offset;
        sel    = {$random(seed)} % 6;
        a      = $random(seed);
        b      = $random(seed);
        offset = $random(seed);  // Ignored by ALU ops
        issue_op(all_ops[sel], a, b, offset, random_rd(), 1'b0, 1'b0);
    endtask

    // Writebacks come out in issue order
    always @(negedge clk)
    begin
        wb_rec_t rec;
        if (!rst && wb_valid)
        begin
            if (expect_q.size() == 0)
            begin
                report_failure("wb_valid pulsed with no operation outstanding");
            end
            else begin
                rec = expect_q.pop_front();
                check_value("wb_reg_write", word_t'(wb_reg_write), word_t'(rec.reg_write));
                check_value("wb_rd", word_t'(wb_rd), word_t'(rec.rd));
                check_value("wb_data", wb_data, rec.data);
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            report_failure($sformatf("Timeout after %0d cycles", cycle_count));
        end
    end

    initial
    begin
        int          k;
        int          kind;
        int          gap;
        word_t       value;
        word_index_t idx;
        word_index_t idx_list [MEM_PAIRS];
        rst        = 1'b1;
        in_valid   = 1'b0;
        alu_op     = alu_add;
        operand_a  = '0;
        operand_b  = '0;
        imm        = '0;
        rd         = '0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        reg_write  = 1'b0;
        mem_to_reg = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Quiet outputs before the first operation
        repeat (8)
        begin
            @(negedge clk);
            check_value("wb_valid", word_t'(wb_valid), '0);
            check_value("wb_reg_write", word_t'(wb_reg_write), '0);
        end

        // Every ALU op back to back, then slt with negative operands
        for (int r = 0; r < ALU_ROUNDS; r++)
        begin
            for (k = 0; k < 6; k++)
            begin
                issue_op(all_ops[k], $random(seed), $random(seed), '0, random_rd(), 1'b0, 1'b0);
            end
        end
        issue_op(alu_slt, 32'hffff_fff0, 32'h0000_0003, '0, random_rd(), 1'b0, 1'b0);
        issue_op(alu_slt, 32'h0000_0005, 32'h8000_0000, '0, random_rd(), 1'b0, 1'b0);
        idle_cycles(4);

        // Store then load the same word on the next cycle
        for (k = 0; k < MEM_PAIRS; k++)
        begin
            idx         = word_index_t'({$random(seed)} % MEM_WORDS);
            value       = $random(seed);
            idx_list[k] = idx;
            store_word(idx, value);
            load_word(idx);
        end
        idle_cycles(3);
        for (k = MEM_PAIRS - 1; k >= 0; k--)
        begin
            load_word(idx_list[k]);  // Later loads, reverse order
        end
        idle_cycles(4);

        // Mixed stream with random gaps
        for (k = 0; k < RANDOM_OPS; k++)
        begin
            kind = {$random(seed)} % 4;
            if (kind == 0)
            begin
                idx = word_index_t'({$random(seed)} % MEM_WORDS);
                store_word(idx, $random(seed));
            end
            else if (kind == 1 && stored_q.size() != 0)
            begin
                load_word(stored_q[{$random(seed)} % stored_q.size()]);
            end
            else begin
                random_alu();
            end
            gap = {$random(seed)} % (MAX_GAP + 1);
            if (gap > 0)
            begin
                idle_cycles(gap);
            end
        end
        idle_cycles(1);

        idle_cycles(6);  // Three-cycle drain plus room for a stray pulse
        if (expect_q.size() != 0)
        begin
            report_failure($sformatf("%0d operations never reached writeback",
                                     expect_q.size()));
        end
        else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

/* all.f */
+incdir+dv
source/isa_pkg.sv
source/mem_map_pkg.sv
source/execute_stage.sv
source/memory_stage.sv
source/data_ram.sv
source/writeback_stage.sv
source/pipe_backend_top.sv
dv/pipe_backend_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f all.f --top-module pipe_backend_tb -o sim_bin

# The simulator exits nonzero on a fatal check, the log decides the verdict
./obj_dir/sim_bin > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
